// ==== flist.f ====
verilog/amo_pkg.sv
verilog/amo_alu.sv
verilog/lr_sc_reservation.sv
verilog/atomic_unit.sv
verilog/data_memory.sv
verilog/amo_subsystem_top.sv
verif/tb_amo_subsystem.sv

// ==== Bender.yml ====
package:
  name: amo_subsystem

sources:
  - verilog/amo_pkg.sv
  - verilog/amo_alu.sv
  - verilog/lr_sc_reservation.sv
  - verilog/atomic_unit.sv
  - verilog/data_memory.sv
  - verilog/amo_subsystem_top.sv
  - target: test
    files:
      - verif/tb_amo_subsystem.sv

// ==== verif/tb_amo_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_amo_subsystem
    import amo_pkg::*;
;

    localparam int MEM_WORDS   = 16;
    localparam int MEM_LATENCY = 2;
    // plain fill and readback, amo trials, lr/sc pairs, failed sc cases, random mix, final dump
    localparam int NUM_ACCESSES = 2 * MEM_WORDS + 9 * 4 * 3 + 4 * 3 + 13 + 300 + MEM_WORDS;

    logic      clk_i;
    logic      rst_i;
    core_req_t core_req;
    mem_rsp_t  core_rsp;

    logic [31:0] lfsr_q = 32'hf453_2a3f;
    logic [31:0] model_mem [MEM_WORDS];
    logic        resv_valid;
    logic [29:0] resv_addr;

    amo_subsystem_top #(
        .MEM_WORDS   (MEM_WORDS),
        .MEM_LATENCY (MEM_LATENCY)
    ) i_dut (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .core_req_i (core_req),
        .core_rsp_o (core_rsp)
    );

    always #5 clk_i = ~clk_i;

    // ====================
    // helpers
    // ====================
    // fibonacci lfsr with taps 32 22 2 1 and one step per bit
    function automatic logic [31:0] rand_bits(input int nbits);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < nbits; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            val    = {val[30:0], fb};
        end
        return val;
    endfunction

    function automatic amo_op_e amo_code(input int sel);
        case (sel)
            0:       return AMO_SWAP;
            1:       return AMO_ADD;
            2:       return AMO_XOR;
            3:       return AMO_AND;
            4:       return AMO_OR;
            5:       return AMO_MIN;
            6:       return AMO_MAX;
            7:       return AMO_MINU;
            default: return AMO_MAXU;
        endcase
    endfunction

    // reference read-modify-write result
    function automatic logic [31:0] model_alu(input amo_op_e op, input logic [31:0] old,
                                              input logic [31:0] src);
        case (op)
            AMO_ADD:  return old + src;
            AMO_XOR:  return old ^ src;
            AMO_AND:  return old & src;
            AMO_OR:   return old | src;
            AMO_MIN:  return ($signed(old) < $signed(src)) ? old : src;
            AMO_MAX:  return ($signed(old) < $signed(src)) ? src : old;
            AMO_MINU: return (old < src) ? old : src;
            AMO_MAXU: return (old < src) ? src : old;
            default:  return src;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
    endtask

    // drives one request until done and compares rdata and model state
    task automatic do_access(input string name, input logic we, input logic is_amo,
                             input amo_op_e op, input logic [31:0] addr,
                             input logic [31:0] wdata);
        int          idx;
        logic [31:0] exp_rdata;
        logic        check_rdata;
        logic        sc_ok;
        logic [31:0] got;
        idx         = (addr >> 2) % MEM_WORDS;
        check_rdata = 1'b1;
        exp_rdata   = model_mem[idx];
        if (!is_amo && we) begin
            model_mem[idx] = wdata;
            check_rdata    = 1'b0;
            if (resv_valid && resv_addr == addr[31:2]) begin
                resv_valid = 1'b0;
            end
        end else if (is_amo && op == AMO_LR) begin
            resv_valid = 1'b1;
            resv_addr  = addr[31:2];
        end else if (is_amo && op == AMO_SC) begin
            sc_ok      = resv_valid && (resv_addr == addr[31:2]);
            resv_valid = 1'b0;
            exp_rdata  = sc_ok ? 32'd0 : 32'd1;
            if (sc_ok) begin
                model_mem[idx] = wdata;
            end
        end else if (is_amo) begin
            model_mem[idx] = model_alu(op, exp_rdata, wdata);
            if (resv_valid && resv_addr == addr[31:2]) begin
                resv_valid = 1'b0;
            end
        end
        core_req.valid  = 1'b1;
        core_req.addr   = addr;
        core_req.we     = we;
        core_req.wdata  = wdata;
        core_req.is_amo = is_amo;
        core_req.amo_op = op;
        do begin
            @(negedge clk_i);
        end while (!core_rsp.done);
        got = core_rsp.rdata;
        @(posedge clk_i);
        #1;
        core_req.valid = 1'b0;
        if (check_rdata) begin
            check_value(name, exp_rdata, got);
        end
        check_value({name, " mem"}, model_mem[idx], i_dut.i_data_memory.mem_q[idx]);
        check_value({name, " resv valid"}, {31'b0, resv_valid},
                    {31'b0, i_dut.i_atomic_unit.i_reservation.resv_valid_q});
        if (resv_valid) begin
            check_value({name, " resv addr"}, {2'b0, resv_addr},
                        {2'b0, i_dut.i_atomic_unit.i_reservation.resv_addr_q});
        end
    endtask

    // ====================
    // watchdog
    // ====================
    initial begin
        repeat (NUM_ACCESSES * (2 * MEM_LATENCY + 4) + 100) @(posedge clk_i);
        $display("timeout: the DUT did not finish all accesses in the expected time");
        $display("TEST RESULT: FAIL");
        $fatal(1);
    end

    // ====================
    // stimulus
    // ====================
    initial begin
        logic [31:0] addr;
        logic [31:0] mv;
        logic [31:0] sv;
        logic [2:0]  sel;
        clk_i      = 1'b0;
        rst_i      = 1'b1;
        core_req   = '0;
        resv_valid = 1'b0;
        resv_addr  = '0;
        repeat (4) begin
            @(posedge clk_i);
            #1;
            check_value("reset done", 32'd0, {31'b0, core_rsp.done});
        end
        rst_i = 1'b0;
        repeat (2) begin
            @(posedge clk_i);
            #1;
            check_value("post reset done", 32'd0, {31'b0, core_rsp.done});
        end

        // plain fill then readback
        for (int i = 0; i < MEM_WORDS; i++) begin
            do_access("plain store", 1'b1, 1'b0, AMO_ADD, 32'(i * 4), rand_bits(32));
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            do_access("plain load", 1'b0, 1'b0, AMO_ADD, 32'(i * 4), 32'd0);
        end

        // every amo code with the first two trials on sign boundaries
        for (int k = 0; k < 9; k++) begin
            for (int t = 0; t < 4; t++) begin
                addr = rand_bits(4) << 2;
                mv   = (t == 0) ? 32'h8000_0000 : (t == 1) ? 32'hffff_ffff : rand_bits(32);
                sv   = (t == 0) ? 32'h7fff_ffff : (t == 1) ? 32'h0000_0001 : rand_bits(32);
                do_access("amo setup", 1'b1, 1'b0, AMO_ADD, addr, mv);
                do_access("amo old", 1'b0, 1'b1, amo_code(k), addr, sv);
                do_access("amo result", 1'b0, 1'b0, AMO_ADD, addr, 32'd0);
            end
        end

        for (int t = 0; t < 4; t++) begin
            addr = rand_bits(4) << 2;
            do_access("lr", 1'b0, 1'b1, AMO_LR, addr, 32'd0);
            do_access("sc pass", 1'b0, 1'b1, AMO_SC, addr, rand_bits(32));
            do_access("sc data", 1'b0, 1'b0, AMO_ADD, addr, 32'd0);
        end

        // failing sc cases
        do_access("sc no resv", 1'b0, 1'b1, AMO_SC, 32'd8, 32'h1111_1111);
        do_access("sc no resv load", 1'b0, 1'b0, AMO_ADD, 32'd8, 32'd0);
        do_access("lr a", 1'b0, 1'b1, AMO_LR, 32'd8, 32'd0);
        do_access("sc other word", 1'b0, 1'b1, AMO_SC, 32'd12, 32'h2222_2222);
        do_access("sc other load", 1'b0, 1'b0, AMO_ADD, 32'd12, 32'd0);
        do_access("lr a", 1'b0, 1'b1, AMO_LR, 32'd8, 32'd0);
        do_access("store to resv", 1'b1, 1'b0, AMO_ADD, 32'd8, 32'h3333_3333);
        do_access("sc after store", 1'b0, 1'b1, AMO_SC, 32'd8, 32'h4444_4444);
        do_access("sc after store load", 1'b0, 1'b0, AMO_ADD, 32'd8, 32'd0);
        do_access("lr a", 1'b0, 1'b1, AMO_LR, 32'd8, 32'd0);
        do_access("first sc", 1'b0, 1'b1, AMO_SC, 32'd8, 32'h5555_5555);
        do_access("second sc", 1'b0, 1'b1, AMO_SC, 32'd8, 32'h6666_6666);
        do_access("second sc load", 1'b0, 1'b0, AMO_ADD, 32'd8, 32'd0);

        // random mix over four words
        for (int n = 0; n < 300; n++) begin
            sel  = 3'(rand_bits(3));
            addr = rand_bits(2) << 2;
            sv   = rand_bits(32);
            case (sel)
                3'd0:    do_access("mix load", 1'b0, 1'b0, AMO_ADD, addr, sv);
                3'd1:    do_access("mix store", 1'b1, 1'b0, AMO_ADD, addr, sv);
                3'd2:    do_access("mix lr", 1'b0, 1'b1, AMO_LR, addr, sv);
                3'd3:    do_access("mix sc", 1'b0, 1'b1, AMO_SC, addr, sv);
                default: do_access("mix amo", 1'b0, 1'b1, amo_code(rand_bits(4) % 9), addr, sv);
            endcase
        end

        for (int i = 0; i < MEM_WORDS; i++) begin
            do_access("final load", 1'b0, 1'b0, AMO_ADD, 32'(i * 4), 32'd0);
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/amo_subsystem_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module amo_subsystem_top
    import amo_pkg::*;
#(
    parameter int MEM_WORDS   = 16,
    parameter int MEM_LATENCY = 2
) (
    input  logic      clk_i,
    input  logic      rst_i,
    input  core_req_t core_req_i,
    output mem_rsp_t  core_rsp_o
);

    // ====================
    // internal memory link
    // ====================
    mem_req_t mem_req;
    mem_rsp_t mem_rsp;

    atomic_unit i_atomic_unit (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .core_req_i (core_req_i),
        .core_rsp_o (core_rsp_o),
        .mem_req_o  (mem_req),
        .mem_rsp_i  (mem_rsp)
    );

    // fixed latency word memory
    data_memory #(
        .MEM_WORDS   (MEM_WORDS),
        .MEM_LATENCY (MEM_LATENCY)
    ) i_data_memory (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .req_i (mem_req),
        .rsp_o (mem_rsp)
    );

endmodule

`default_nettype wire

// ==== verilog/data_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_memory
    import amo_pkg::*;
#(
    parameter int MEM_WORDS   = 16,
    parameter int MEM_LATENCY = 2
) (
    input  logic     clk_i,
    input  logic     rst_i,
    input  mem_req_t req_i,
    output mem_rsp_t rsp_o
);

    localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
    localparam int CNT_W = (MEM_LATENCY > 1) ? $clog2(MEM_LATENCY) : 1;

    logic [XLEN-1:0]  mem_q [MEM_WORDS];
    logic             busy_q;
    logic [CNT_W-1:0] cnt_q;
    logic [IDX_W-1:0] idx_q;
    logic             we_q;
    logic [XLEN-1:0]  wdata_q;
    logic [IDX_W-1:0] req_idx;
    logic             accept;
    logic             done;

    // word index wraps at the memory depth
    assign req_idx = IDX_W'((req_i.addr >> 2) % MEM_WORDS);

    assign accept = req_i.valid && !busy_q;
    assign done   = busy_q && (cnt_q == CNT_W'(MEM_LATENCY - 1));

    // ====================
    // latency counter
    // ====================
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
        end else if (accept) begin
            busy_q <= 1'b1;
            cnt_q  <= '0;
        end else if (done) begin
            busy_q <= 1'b0;
        end else if (busy_q) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // ====================
    // storage
    // ====================
    always_ff @(posedge clk_i) begin
        if (accept) begin
            idx_q   <= req_idx;
            we_q    <= req_i.we;
            wdata_q <= req_i.wdata;
        end
        if (done && we_q) begin
            mem_q[idx_q] <= wdata_q;
        end
    end

    assign rsp_o = '{done: done, rdata: mem_q[idx_q]};

    // requester keeps valid up to and including the done cycle
    a_done_with_valid: assert property (
        @(posedge clk_i) disable iff (rst_i) rsp_o.done |-> req_i.valid
    );

endmodule

`default_nettype wire

// ==== verilog/atomic_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module atomic_unit
    import amo_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,
    input  core_req_t core_req_i,
    output mem_rsp_t  core_rsp_o,
    output mem_req_t  mem_req_o,
    input  mem_rsp_t  mem_rsp_i
);

    typedef enum logic [1:0] {
        ST_BYPASS,
        ST_AMO_READ,
        ST_AMO_WRITE,
        ST_AMO_FINISH
    } state_e;

    state_e          state_q;
    state_e          state_d;
    logic            is_lr;
    logic            is_sc;
    logic            amo_start;
    logic            sc_ok;
    logic            sc_lost;
    logic            sc_fail_q;
    logic [XLEN-1:0] old_q;
    logic [XLEN-1:0] alu_result;
    logic            mem_write_done;

    assign is_lr     = (core_req_i.amo_op == AMO_LR);
    assign is_sc     = (core_req_i.amo_op == AMO_SC);
    assign amo_start = (state_q == ST_BYPASS) && core_req_i.valid && core_req_i.is_amo;
    assign sc_lost   = is_sc && !sc_ok;

    // ====================
    // FSM
    // ====================
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_BYPASS: begin
                if (amo_start) begin
                    state_d = sc_lost ? ST_AMO_FINISH : ST_AMO_READ;
                end
            end
            ST_AMO_READ: begin
                if (mem_rsp_i.done) begin
                    state_d = is_lr ? ST_AMO_FINISH : ST_AMO_WRITE;
                end
            end
            ST_AMO_WRITE: begin
                if (mem_rsp_i.done) begin
                    state_d = ST_AMO_FINISH;
                end
            end
            default: begin
                state_d = ST_BYPASS;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q   <= ST_BYPASS;
            sc_fail_q <= 1'b0;
        end else begin
            state_q <= state_d;
            // sc outcome frozen here, the check itself clears the reservation
            if (amo_start) begin
                sc_fail_q <= sc_lost;
            end
        end
    end

    // old word from the read phase
    always_ff @(posedge clk_i) begin
        if (state_q == ST_AMO_READ && mem_rsp_i.done) begin
            old_q <= mem_rsp_i.rdata;
        end
    end

    // ====================
    // memory side
    // ====================
    always_comb begin
        mem_req_o = '{valid: 1'b0, addr: core_req_i.addr, we: 1'b0, wdata: alu_result};
        case (state_q)
            ST_BYPASS: begin
                if (!core_req_i.is_amo) begin
                    mem_req_o.valid = core_req_i.valid;
                    mem_req_o.we    = core_req_i.we;
                    mem_req_o.wdata = core_req_i.wdata;
                end else begin
                    // read goes out at acceptance, a lost sc skips memory
                    mem_req_o.valid = core_req_i.valid && !sc_lost;
                end
            end
            ST_AMO_READ: begin
                mem_req_o.valid = 1'b1;
            end
            ST_AMO_WRITE: begin
                // alu passes the sc data through unchanged
                mem_req_o.valid = 1'b1;
                mem_req_o.we    = 1'b1;
            end
            default: begin
                mem_req_o.valid = 1'b0;
            end
        endcase
    end

    // ====================
    // core side
    // ====================
    always_comb begin
        core_rsp_o = '{done: 1'b0, rdata: old_q};
        if (state_q == ST_BYPASS && !core_req_i.is_amo) begin
            core_rsp_o = mem_rsp_i;
        end else if (state_q == ST_AMO_FINISH) begin
            core_rsp_o.done = 1'b1;
            if (is_sc) begin
                core_rsp_o.rdata = XLEN'(sc_fail_q);
            end
        end
    end

    assign mem_write_done = mem_req_o.valid && mem_req_o.we && mem_rsp_i.done;

    amo_alu i_amo_alu (
        .op_i      (core_req_i.amo_op),
        .mem_val_i (old_q),
        .src_val_i (core_req_i.wdata),
        .result_o  (alu_result)
    );

    lr_sc_reservation i_reservation (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .addr_i       (core_req_i.addr),
        .set_i        ((state_q == ST_AMO_FINISH) && is_lr),
        .sc_i         (amo_start && is_sc),
        .store_i      (mem_write_done),
        .store_addr_i (mem_req_o.addr),
        .sc_ok_o      (sc_ok)
    );

    a_core_done_pulse: assert property (
        @(posedge clk_i) disable iff (rst_i) core_rsp_o.done |=> !core_rsp_o.done
    );

    // core holds its request for the whole atomic sequence
    a_core_req_stable: assert property (
        @(posedge clk_i) disable iff (rst_i)
        (amo_start || state_q == ST_AMO_READ || state_q == ST_AMO_WRITE)
            |=> $stable(core_req_i)
    );

endmodule

`default_nettype wire

// ==== verilog/lr_sc_reservation.sv ====
`timescale 1ns/1ps
`default_nettype none

module lr_sc_reservation
    import amo_pkg::*;
(
    input  logic            clk_i,
    input  logic            rst_i,
    input  logic [XLEN-1:0] addr_i,
    input  logic            set_i,
    input  logic            sc_i,
    input  logic            store_i,
    input  logic [XLEN-1:0] store_addr_i,
    output logic            sc_ok_o
);

    logic            resv_valid_q;
    logic [XLEN-3:0] resv_addr_q;
    logic            store_hit;

    // word compare, byte offset ignored
    assign store_hit = store_i && resv_valid_q && (store_addr_i[XLEN-1:2] == resv_addr_q);
    assign sc_ok_o   = resv_valid_q && (addr_i[XLEN-1:2] == resv_addr_q);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            resv_valid_q <= 1'b0;
        end else if (set_i) begin
            resv_valid_q <= 1'b1;
        end else if (sc_i || store_hit) begin
            resv_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (set_i) begin
            resv_addr_q <= addr_i[XLEN-1:2];
        end
    end

    // lr completes in the finish cycle, sc is checked at acceptance
    a_set_sc_exclusive: assert property (
        @(posedge clk_i) disable iff (rst_i) !(set_i && sc_i)
    );

endmodule

`default_nettype wire

// ==== verilog/amo_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module amo_alu
    import amo_pkg::*;
(
    input  amo_op_e         op_i,
    input  logic [XLEN-1:0] mem_val_i,
    input  logic [XLEN-1:0] src_val_i,
    output logic [XLEN-1:0] result_o
);

    logic [XLEN:0] mem_ext;
    logic [XLEN:0] src_ext;
    logic          mem_lt_src;

    // ====================
    // shared comparator
    // ====================
    // extra top bit carries the sign only for MIN/MAX,
    // zero for MINU/MAXU so the signed compare acts unsigned
    assign mem_ext = {~op_i[3] & mem_val_i[XLEN-1], mem_val_i};
    assign src_ext = {~op_i[3] & src_val_i[XLEN-1], src_val_i};

    assign mem_lt_src = $signed(mem_ext) < $signed(src_ext);

    // ====================
    // store-back value
    // ====================
    always_comb begin
        case (op_i)
            AMO_ADD: begin
                result_o = mem_val_i + src_val_i;
            end
            AMO_XOR: begin
                result_o = mem_val_i ^ src_val_i;
            end
            AMO_AND: begin
                result_o = mem_val_i & src_val_i;
            end
            AMO_OR: begin
                result_o = mem_val_i | src_val_i;
            end
            AMO_MIN, AMO_MINU: begin
                result_o = mem_lt_src ? mem_val_i : src_val_i;
            end
            AMO_MAX, AMO_MAXU: begin
                result_o = mem_lt_src ? src_val_i : mem_val_i;
            end
            // swap, sc and anything unknown store the core operand
            default: begin
                result_o = src_val_i;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/amo_pkg.sv ====
`default_nettype none

package amo_pkg;

    // ====================
    // widths
    // ====================
    parameter int XLEN = 32;

    // ====================
    // atomic operations
    // ====================
    // funct5 codes, bit 3 marks the unsigned min/max variants
    typedef enum logic [4:0] {
        AMO_ADD  = 5'b00000,
        AMO_SWAP = 5'b00001,
        AMO_LR   = 5'b00010,
        AMO_SC   = 5'b00011,
        AMO_XOR  = 5'b00100,
        AMO_OR   = 5'b01000,
        AMO_AND  = 5'b01100,
        AMO_MIN  = 5'b10000,
        AMO_MAX  = 5'b10100,
        AMO_MINU = 5'b11000,
        AMO_MAXU = 5'b11100
    } amo_op_e;

    // ====================
    // bus structs
    // ====================
    // core request, held until done
    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] addr;
        logic            we;
        logic [XLEN-1:0] wdata;
        logic            is_amo;
        amo_op_e         amo_op;
    } core_req_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] addr;
        logic            we;
        logic [XLEN-1:0] wdata;
    } mem_req_t;

    // completion, shared by memory and core side
    typedef struct packed {
        logic            done;
        logic [XLEN-1:0] rdata;
    } mem_rsp_t;

endpackage

`default_nettype wire
